// File: Bender.yml
package:
  name: radar_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/radar_pkg.sv
      - rtl/setting_reg.sv
      - rtl/radar_control.sv
      - rtl/radar_chirp_gen.sv
      - rtl/radar_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/radar_top_tb.sv

// File: include/radar_macros.svh
/*
 * Radar pulse controller register map, configuration bus widths
 * and mode word bit positions
 */
`ifndef RADAR_MACROS_SVH
`define RADAR_MACROS_SVH

// Configuration bus geometry
`define RADAR_ADDR_W 7
`define RADAR_DATA_W 32

// Register addresses, eight consecutive words from 64
`define FR_RADAR_MODE   7'd64
`define FR_RADAR_TON    7'd65
`define FR_RADAR_TSW    7'd66
`define FR_RADAR_TLOOK  7'd67
`define FR_RADAR_TIDLE  7'd68
`define FR_RADAR_AMPL   7'd69
`define FR_RADAR_FSTART 7'd70
`define FR_RADAR_FINCR  7'd71

// Mode word fields
`define RADAR_MODE_RESET    0
`define RADAR_MODE_TX_SIDE  1
// Reserved enables: low power, multi duty, dual rate
`define RADAR_MODE_LP_ENA   2
`define RADAR_MODE_MD_ENA   3
`define RADAR_MODE_DR_ENA   4
// Two bit chirp mode field
`define RADAR_MODE_CHIRP_LO 5
`define RADAR_MODE_CHIRP_HI 6
`define RADAR_MODE_DEBUG    7

`endif

// File: radar_top.f
+incdir+include
rtl/radar_pkg.sv
rtl/setting_reg.sv
rtl/radar_control.sv
rtl/radar_chirp_gen.sv
rtl/radar_top.sv
tests/radar_top_tb.sv

// File: rtl/radar_chirp_gen.sv
/*
 * Transmit chirp generator: frequency ramp, phase accumulator
 * and amplitude gating during the transmit phase
 */
`default_nettype none

module radar_chirp_gen (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  radar_pkg::chirp_cfg_t   chirp_cfg_i,
   input  radar_pkg::pulse_ctrl_t  pulse_ctrl_i,
   output radar_pkg::tx_out_t      tx_o
);

   import radar_pkg::*;

   logic        tx_d;
   logic        first_tx;
   chirp_mode_e ramp_mode;
   chirp_mode_e ramp_q;
   logic [31:0] freq_q;
   logic [31:0] freq_next;
   logic [15:0] phase_q;
   logic [15:0] ampl_q;

   // Rising edge of tx_ctrl marks the first transmit cycle
   assign first_tx = pulse_ctrl_i.tx_ctrl && !tx_d;

   // Alternate mode resolves to a direction from the pulse parity
   always_comb
   begin
      ramp_mode = chirp_cfg_i.mode;
      if (chirp_cfg_i.mode == CHIRP_ALT)
         ramp_mode = pulse_ctrl_i.pulse_num[0] ? CHIRP_DOWN : CHIRP_UP;
   end

   // Next frequency: load, step on strobe, otherwise hold
   always_comb
   begin
      freq_next = freq_q;
      if (first_tx)
         freq_next = chirp_cfg_i.fstart;
      else if (pulse_ctrl_i.tx_ctrl && pulse_ctrl_i.tx_strobe)
      begin
         case (ramp_q)
            CHIRP_UP:   freq_next = freq_q + chirp_cfg_i.fincr;
            CHIRP_DOWN: freq_next = freq_q - chirp_cfg_i.fincr;
            // CW holds the start value
            default:    freq_next = freq_q;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         tx_d    <= 1'b0;
         ramp_q  <= CHIRP_CW;
         freq_q  <= '0;
         phase_q <= '0;
         ampl_q  <= '0;
      end
      else
      begin
         tx_d   <= pulse_ctrl_i.tx_ctrl;
         freq_q <= freq_next;
         // Direction fixed for the whole pulse
         if (first_tx)
            ramp_q <= ramp_mode;
         // Phase advances by the coarse frequency while transmitting
         if (pulse_ctrl_i.tx_ctrl)
            phase_q <= phase_q + freq_next[31:16];
         ampl_q <= pulse_ctrl_i.tx_ctrl ? chirp_cfg_i.ampl : 16'd0;
      end
   end

   assign tx_o.ampl  = ampl_q;
   assign tx_o.freq  = freq_q;
   assign tx_o.phase = phase_q;

endmodule

`default_nettype wire

// File: rtl/radar_control.sv
/*
 * Radar configuration register bank, mode word decode and
 * four phase pulse sequencer with pulse counter and transmit strobe
 */
`default_nettype none

`include "radar_macros.svh"

module radar_control (
   input  logic                    clk_i,
   input  radar_pkg::cfg_bus_t     cfg_i,
   output logic                    reset_o,
   output logic                    tx_side_o,
   output logic                    dbg_o,
   output radar_pkg::chirp_cfg_t   chirp_cfg_o,
   output radar_pkg::pulse_ctrl_t  pulse_ctrl_o
);

   import radar_pkg::*;

   // Register bank outputs
   logic [31:0] mode;
   logic [15:0] t_on;
   logic [15:0] t_sw;
   logic [15:0] t_look;
   logic [31:0] t_idle;
   logic [15:0] ampl;
   logic [31:0] fstart;
   logic [31:0] fincr;

   // Sequencer state
   radar_phase_e phase;
   logic [31:0]  count;
   logic [15:0]  pulse_num;

   setting_reg #(.ADDR(`FR_RADAR_MODE), .WIDTH(32)) i_sr_mode (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(mode)
   );

   setting_reg #(.ADDR(`FR_RADAR_TON), .WIDTH(16)) i_sr_ton (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(t_on)
   );

   setting_reg #(.ADDR(`FR_RADAR_TSW), .WIDTH(16)) i_sr_tsw (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(t_sw)
   );

   setting_reg #(.ADDR(`FR_RADAR_TLOOK), .WIDTH(16)) i_sr_tlook (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(t_look)
   );

   // Idle may be long, so keep the full word
   setting_reg #(.ADDR(`FR_RADAR_TIDLE), .WIDTH(32)) i_sr_tidle (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(t_idle)
   );

   setting_reg #(.ADDR(`FR_RADAR_AMPL), .WIDTH(16)) i_sr_ampl (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(ampl)
   );

   setting_reg #(.ADDR(`FR_RADAR_FSTART), .WIDTH(32)) i_sr_fstart (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(fstart)
   );

   setting_reg #(.ADDR(`FR_RADAR_FINCR), .WIDTH(32)) i_sr_fincr (
      .clk_i(clk_i), .cfg_i(cfg_i), .value_o(fincr)
   );

   // Mode decode
   // Bits 2 to 4 are the reserved low-power, multi-duty and dual-rate enables
   assign reset_o   = mode[`RADAR_MODE_RESET];
   assign tx_side_o = mode[`RADAR_MODE_TX_SIDE];
   assign dbg_o     = mode[`RADAR_MODE_DEBUG];

   assign chirp_cfg_o.ampl   = ampl;
   assign chirp_cfg_o.fstart = fstart;
   assign chirp_cfg_o.fincr  = fincr;
   assign chirp_cfg_o.mode   =
      chirp_mode_e'(mode[`RADAR_MODE_CHIRP_HI:`RADAR_MODE_CHIRP_LO]);

   // Each phase lasts its duration plus one cycle
   always_ff @(posedge clk_i)
   begin
      if (reset_o)
      begin
         phase     <= PH_ON;
         count     <= '0;
         pulse_num <= '0;
      end
      else
      begin
         case (phase)
            PH_ON:
               if (count == {16'b0, t_on})
               begin
                  phase     <= PH_SW;
                  count     <= '0;
                  // Pulse number advances as transmit ends
                  pulse_num <= pulse_num + 16'd1;
               end
               else
                  count <= count + 32'd1;
            PH_SW:
               if (count == {16'b0, t_sw})
               begin
                  phase <= PH_LOOK;
                  count <= '0;
               end
               else
                  count <= count + 32'd1;
            PH_LOOK:
               if (count == {16'b0, t_look})
               begin
                  phase <= PH_IDLE;
                  count <= '0;
               end
               else
                  count <= count + 32'd1;
            PH_IDLE:
               if (count == t_idle)
               begin
                  phase <= PH_ON;
                  count <= '0;
               end
               else
                  count <= count + 32'd1;
            // Recover from a corrupted phase code
            default:
            begin
               phase <= PH_ON;
               count <= '0;
            end
         endcase
      end
   end

   // Half rate DAC strobe on odd counts
   assign pulse_ctrl_o.tx_strobe = count[0];
   assign pulse_ctrl_o.tx_ctrl   = (phase == PH_ON);
   assign pulse_ctrl_o.rx_ctrl   = (phase == PH_LOOK);
   assign pulse_ctrl_o.pulse_num = pulse_num;

endmodule

`default_nettype wire

// File: rtl/radar_pkg.sv
/*
 * Shared radar types: configuration bus word, chirp settings,
 * pulse sequencer status, transmit output, phase and chirp enums
 */
`default_nettype none

`include "radar_macros.svh"

package radar_pkg;

   // One write on the configuration bus
   typedef struct packed {
      logic [`RADAR_ADDR_W-1:0] addr;
      logic [`RADAR_DATA_W-1:0] data;
      logic                     strobe;
   } cfg_bus_t;

   // Ramp behaviour, alternate flips direction by pulse parity
   typedef enum logic [1:0] {
      CHIRP_UP   = 2'd0,
      CHIRP_DOWN = 2'd1,
      CHIRP_ALT  = 2'd2,
      CHIRP_CW   = 2'd3
   } chirp_mode_e;

   // One-hot pulse phase
   typedef enum logic [3:0] {
      PH_ON   = 4'b0001,
      PH_SW   = 4'b0010,
      PH_LOOK = 4'b0100,
      PH_IDLE = 4'b1000
   } radar_phase_e;

   // Transmit settings for the chirp generator
   typedef struct packed {
      logic [15:0] ampl;
      logic [31:0] fstart;
      logic [31:0] fincr;
      chirp_mode_e mode;
   } chirp_cfg_t;

   // Sequencer status
   typedef struct packed {
      logic        tx_ctrl;
      logic        rx_ctrl;
      logic        tx_strobe;
      logic [15:0] pulse_num;
   } pulse_ctrl_t;

   // Transmit sample parameters
   typedef struct packed {
      logic [15:0] ampl;
      logic [31:0] freq;
      logic [15:0] phase;
   } tx_out_t;

endpackage

`default_nettype wire

// File: rtl/radar_top.sv
/*
 * Radar pulse timing subsystem top: control block and chirp generator
 */
`default_nettype none

module radar_top (
   // Host side
   input  logic                    clk_i,
   input  radar_pkg::cfg_bus_t     cfg_i,
   // Host controlled subsystem reset
   output logic                    reset_o,
   output logic                    tx_side_o,
   output logic                    dbg_o,
   // Sequencer status toward the RF front end
   output radar_pkg::pulse_ctrl_t  ctrl_o,
   // Transmit parameters toward the DAC path
   output radar_pkg::tx_out_t      tx_o
);

   // Transmit settings from the register bank
   radar_pkg::chirp_cfg_t chirp_cfg;

   // Register bank and pulse sequencer
   radar_control i_radar_control (
      .clk_i        (clk_i),
      .cfg_i        (cfg_i),
      .reset_o      (reset_o),
      .tx_side_o    (tx_side_o),
      .dbg_o        (dbg_o),
      .chirp_cfg_o  (chirp_cfg),
      .pulse_ctrl_o (ctrl_o)
   );

   // Chirp generator runs off the same mode reset
   // and follows the sequencer status one cycle later
   radar_chirp_gen i_radar_chirp_gen (
      .clk_i        (clk_i),
      .reset_i      (reset_o),
      .chirp_cfg_i  (chirp_cfg),
      .pulse_ctrl_i (ctrl_o),
      .tx_o         (tx_o)
   );

endmodule

`default_nettype wire

// File: rtl/setting_reg.sv
/*
 * Single addressed configuration register on the strobe bus
 */
`default_nettype none

`include "radar_macros.svh"

module setting_reg #(
   // Address this register answers to
   parameter logic [`RADAR_ADDR_W-1:0] ADDR = '0,
   // Stored width, low bits of the data word
   parameter int unsigned WIDTH = `RADAR_DATA_W
) (
   input  logic                 clk_i,
   input  radar_pkg::cfg_bus_t  cfg_i,
   output logic [WIDTH-1:0]     value_o
);

   logic hit;

   // Address match qualified by the write strobe
   assign hit = cfg_i.strobe && (cfg_i.addr == ADDR);

   // New value visible the cycle after the write
   always_ff @(posedge clk_i)
   begin
      if (hit)
      begin
         value_o <= cfg_i.data[WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

// File: tests/radar_stimulus.txt
// Hex words read in order, the first word is the record count
// Record: mode t_on t_sw t_look t_idle ampl fstart fincr / npulses final_pulse_num / end freq per pulse
00000006

// Up chirp, tx side set, four steps per pulse
00000002 00000007 00000002 00000005 00000003 00001234 01000000 00010000
00000003 00000003
01040000 01040000 01040000

// Down chirp with debug, zero switch and idle durations
000000a0 00000008 00000000 00000003 00000000 00007fff 20000000 00100000
00000002 00000002
1fc00000 1fc00000

// CW with reserved enables set, step is ignored
0000007e 00000004 00000001 00000002 00000005 00000abc 12345678 11111111
00000002 00000002
12345678 12345678

// Alternate chirp, up on even pulses and down on odd ones
000000c2 00000005 00000001 00000001 00000002 00000100 40000000 00030000
00000004 00000004
40090000 3ff70000 40090000 3ff70000

// Single cycle transmit, no strobe so the start value stays
00000000 00000000 00000003 00000000 00000001 0000ffff 00000100 00000010
00000002 00000002
00000100 00000100

// Down chirp wrapping below zero
00000020 00000003 00000000 00000000 00000000 00000001 00000005 00000004
00000003 00000003
fffffffd fffffffd fffffffd

// File: tests/radar_top_tb.sv
/*
 * Testbench for the radar pulse subsystem: reads configuration records,
 * programs the registers over the strobe bus, checks sequencer and chirp outputs
 */
`default_nettype none

`include "radar_macros.svh"

module radar_top_tb;

   import radar_pkg::*;

   localparam int STIM_WORDS = 256;

   // DUT connections
   logic        clk;
   cfg_bus_t    cfg;
   logic        reset;
   logic        tx_side;
   logic        dbg;
   pulse_ctrl_t ctrl;
   tx_out_t     tx;

   // Stimulus words and run state
   logic [31:0] stim [0:STIM_WORDS-1];
   int          ptr;
   int          n_rec;
   int          rec;
   int          errors;
   int          timeouts;
   // Amplitude follows tx_ctrl of the previous sample
   logic        amp_chk;
   logic        prev_tx;
   logic [15:0] cur_ampl;

   radar_top i_radar_top (
      .clk_i     (clk),
      .cfg_i     (cfg),
      .reset_o   (reset),
      .tx_side_o (tx_side),
      .dbg_o     (dbg),
      .ctrl_o    (ctrl),
      .tx_o      (tx)
   );

   initial
      clk = 1'b0;

   always #5 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Outputs are stable at the falling edge
   task automatic sample_cycle();
      @(negedge clk);
      if (amp_chk)
         check("tx_o.ampl", tx.ampl, prev_tx ? cur_ampl : 16'd0);
      prev_tx = ctrl.tx_ctrl && !reset;
   endtask

   task automatic drive_cycle(input logic [`RADAR_ADDR_W-1:0] addr,
                              input logic [`RADAR_DATA_W-1:0] data,
                              input logic                     strobe);
      @(posedge clk);
      cfg.addr   <= addr;
      cfg.data   <= data;
      cfg.strobe <= strobe;
      sample_cycle();
   endtask

   // One strobed write followed by an idle cycle
   task automatic bus_write(input logic [`RADAR_ADDR_W-1:0] addr,
                            input logic [`RADAR_DATA_W-1:0] data);
      drive_cycle(addr, data, 1'b1);
      drive_cycle(addr, data, 1'b0);
   endtask

   // Mode outputs settle one cycle after the write
   task automatic write_mode(input logic [31:0] m);
      bus_write(`FR_RADAR_MODE, m);
      check("reset_o", reset, m[`RADAR_MODE_RESET]);
      check("tx_side_o", tx_side, m[`RADAR_MODE_TX_SIDE]);
      check("dbg_o", dbg, m[`RADAR_MODE_DEBUG]);
   endtask

   task automatic check_reset_state();
      sample_cycle();
      check("reset_o", reset, 1'b1);
      check("ctrl_o.tx_ctrl", ctrl.tx_ctrl, 1'b1);
      check("ctrl_o.rx_ctrl", ctrl.rx_ctrl, 1'b0);
      check("ctrl_o.tx_strobe", ctrl.tx_strobe, 1'b0);
      check("ctrl_o.pulse_num", ctrl.pulse_num, 16'd0);
      check("tx_o.ampl", tx.ampl, 16'd0);
      check("tx_o.freq", tx.freq, 32'd0);
      check("tx_o.phase", tx.phase, 16'd0);
   endtask

   // 0 transmit, 1 look, 2 neither
   function automatic logic in_phase(input int sel);
      case (sel)
         0:       in_phase = ctrl.tx_ctrl;
         1:       in_phase = ctrl.rx_ctrl;
         default: in_phase = !ctrl.tx_ctrl && !ctrl.rx_ctrl;
      endcase
   endfunction

   // Ramp direction of one pulse, +1 up, -1 down and 0 for CW
   function automatic int ramp_dir(input logic [1:0] field, input int pulse);
      case (field)
         CHIRP_UP:   ramp_dir = 1;
         CHIRP_DOWN: ramp_dir = -1;
         CHIRP_ALT:  ramp_dir = (pulse % 2 == 0) ? 1 : -1;
         default:    ramp_dir = 0;
      endcase
   endfunction

   // Sum of the top frequency bits over all transmit cycles of one pulse
   function automatic logic [15:0] phase_gain(input logic [31:0] fstart,
                                              input logic [31:0] step,
                                              input int          dir,
                                              input int          t_on);
      logic [31:0] f;
      logic [15:0] acc;
      int          k;
      acc = '0;
      for (k = 0; k <= t_on; k++)
      begin
         // Odd counts up to k have each applied one step
         f   = fstart + step * ((k + 1) / 2) * dir;
         acc = acc + f[31:16];
      end
      phase_gain = acc;
   endfunction

   // Counts cycles and strobes until the phase ends, bounded by lim
   task automatic measure_phase(input int sel, input string name, input int lim,
                                output int cycles, output int strobes);
      cycles  = 0;
      strobes = 0;
      while (in_phase(sel) && cycles <= lim)
      begin
         cycles++;
         strobes += ctrl.tx_strobe;
         sample_cycle();
      end
      if (cycles > lim)
      begin
         timeouts++;
         $display("Timeout: the %s did not end within %0d cycles", name, lim);
      end
   endtask

   task automatic run_record();
      logic [31:0] mode;
      logic [31:0] t_on;
      logic [31:0] t_sw;
      logic [31:0] t_look;
      logic [31:0] t_idle;
      logic [15:0] exp_phase;
      int          npulses;
      int          lim;
      int          p;
      int          cycles;
      int          strobes;

      mode      = stim[ptr];
      t_on      = stim[ptr + 1];
      t_sw      = stim[ptr + 2];
      t_look    = stim[ptr + 3];
      t_idle    = stim[ptr + 4];
      cur_ampl  = stim[ptr + 5][15:0];
      npulses   = stim[ptr + 8];
      exp_phase = '0;
      // Longest wait is below one full pulse period
      lim       = t_on + t_sw + t_look + t_idle + 8;

      // Subsystem held in reset while the registers are loaded
      amp_chk = 1'b0;
      write_mode(mode | (32'h1 << `RADAR_MODE_RESET));
      check_reset_state();
      check_reset_state();
      bus_write(`FR_RADAR_TON, t_on);
      bus_write(`FR_RADAR_TSW, t_sw);
      bus_write(`FR_RADAR_TLOOK, t_look);
      bus_write(`FR_RADAR_TIDLE, t_idle);
      bus_write(`FR_RADAR_AMPL, stim[ptr + 5]);
      bus_write(`FR_RADAR_FSTART, stim[ptr + 6]);
      bus_write(`FR_RADAR_FINCR, stim[ptr + 7]);
      amp_chk = 1'b1;
      // Release lands on the first transmit cycle
      write_mode(mode & ~(32'h1 << `RADAR_MODE_RESET));

      for (p = 0; p < npulses && timeouts == 0; p++)
      begin
         check("ctrl_o.pulse_num", ctrl.pulse_num, p);
         measure_phase(0, "transmit phase", lim, cycles, strobes);
         check("tx_ctrl high cycles", cycles, t_on + 1);
         check("tx_strobe count", strobes, (t_on + 1) / 2);
         // Count advances as transmit ends
         check("ctrl_o.pulse_num", ctrl.pulse_num, p + 1);
         measure_phase(2, "switch gap", lim, cycles, strobes);
         check("switch gap cycles", cycles, t_sw + 1);
         // First look cycle shows the pulse end frequency
         check("tx_o.freq", tx.freq, stim[ptr + 10 + p]);
         // Phase keeps accumulating from pulse to pulse until reset
         exp_phase = exp_phase + phase_gain(stim[ptr + 6], stim[ptr + 7],
            ramp_dir(mode[`RADAR_MODE_CHIRP_HI:`RADAR_MODE_CHIRP_LO], p), t_on);
         check("tx_o.phase", tx.phase, exp_phase);
         measure_phase(1, "look phase", lim, cycles, strobes);
         check("rx_ctrl high cycles", cycles, t_look + 1);
         measure_phase(2, "idle gap", lim, cycles, strobes);
         check("idle gap cycles", cycles, t_idle + 1);
      end
      check("final ctrl_o.pulse_num", ctrl.pulse_num, stim[ptr + 9]);
      ptr = ptr + 10 + npulses;
   endtask

   initial
   begin
      cfg.addr   = '0;
      cfg.data   = '0;
      cfg.strobe = 1'b0;
      errors     = 0;
      timeouts   = 0;
      amp_chk    = 1'b0;
      prev_tx    = 1'b0;
      cur_ampl   = '0;
      $readmemh("tests/radar_stimulus.txt", stim);
      ptr = 1;
      if ($isunknown(stim[0]) || stim[0] == 0)
      begin
         errors++;
         $display("The stimulus file is missing or holds no records");
      end
      else
      begin
         n_rec = stim[0];
         for (rec = 0; rec < n_rec && timeouts == 0; rec++)
            run_record();
      end
      $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
